// ==== hw/wisc_pkg.sv ====
package wisc_pkg;

	localparam int DATA_W = 16;
	localparam int NREG   = 8;
	localparam int REG_AW = $clog2(NREG);

	// Order follows the 5-bit instruction encoding.
	typedef enum logic [4:0] {
		op_halt = 5'b0_0000, op_nop, op_siic, op_rti,
		op_j, op_jr, op_jal, op_jalr,
		op_addi, op_subi, op_xori, op_andni,
		op_beqz, op_bnez, op_bltz, op_bgez,
		op_st, op_ld, op_slbi, op_stu,
		op_roli, op_slli, op_rori, op_srli,
		op_lbi, op_btr, op_alu_add_sub, op_alu_logic_shift,
		op_seq, op_slt, op_sle, op_sco
	} opcode_e;

	// Low two bits of each group line up with opcode and funct bits.
	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_xor, alu_andn,
		alu_rol, alu_sll, alu_ror, alu_srl,
		alu_seq, alu_slt, alu_sle, alu_sco,
		alu_btr, alu_slbi, alu_pass_b
	} alu_op_e;

	typedef enum logic [1:0] {dst_rd_r, dst_rd_i, dst_rs, dst_r7} dst_sel_e;

	typedef enum logic [1:0] {wb_alu, wb_mem, wb_link, wb_imm} wb_sel_e;

	typedef enum logic [2:0] {
		imm_imm5_sext, imm_imm5_zext, imm_imm8_sext, imm_imm8_zext, imm_disp11_sext
	} imm_sel_e;

	typedef enum logic [2:0] {br_none, br_eqz, br_nez, br_ltz, br_gez} br_cond_e;

	typedef enum logic [1:0] {jmp_none, jmp_rel, jmp_reg} jump_e;

	typedef enum logic [2:0] {
		s_fetch_req, s_fetch_rel, s_execute, s_mem_req,
		s_mem_rel, s_writeback, s_halted, s_errored
	} state_e;

endpackage

// ==== hw/control.sv ====
`timescale 1ns/1ps

module control import wisc_pkg::*; (
	input  opcode_e    i_opcode,
	input  logic [1:0] i_funct,
	output dst_sel_e   o_dst_sel,
	output wb_sel_e    o_wb_sel,
	output imm_sel_e   o_imm_sel,
	output logic       o_alu_src_imm,
	output alu_op_e    o_alu_op,
	output logic       o_reg_write,
	output logic       o_mem_read,
	output logic       o_mem_write,
	output br_cond_e   o_br_cond,
	output jump_e      o_jump,
	output logic       o_halt,
	output logic       o_err
);

	always_comb begin
		o_dst_sel     = dst_rd_r;
		o_wb_sel      = wb_alu;
		o_imm_sel     = imm_imm5_sext;
		o_alu_src_imm = 1'b0;
		o_alu_op      = alu_pass_b;
		o_reg_write   = 1'b0;
		o_mem_read    = 1'b0;
		o_mem_write   = 1'b0;
		o_br_cond     = br_none;
		o_jump        = jmp_none;
		o_halt        = 1'b0;
		o_err         = 1'b0;

		case (i_opcode)
			op_halt: begin
				o_halt = 1'b1;
			end

			op_nop: begin
			end

			// Exception return path is not implemented.
			op_siic, op_rti: begin
				o_err = 1'b1;
			end

			op_j, op_jal: begin
				o_imm_sel = imm_disp11_sext;
				o_jump    = jmp_rel;
				if (i_opcode == op_jal) begin
					o_reg_write = 1'b1;
					o_dst_sel   = dst_r7;
					o_wb_sel    = wb_link;
				end
			end

			op_jr, op_jalr: begin
				o_imm_sel = imm_imm8_sext;
				o_jump    = jmp_reg;
				if (i_opcode == op_jalr) begin
					o_reg_write = 1'b1;
					o_dst_sel   = dst_r7;
					o_wb_sel    = wb_link;
				end
			end

			op_addi, op_subi, op_xori, op_andni: begin
				o_dst_sel     = dst_rd_i;
				o_alu_src_imm = 1'b1;
				o_reg_write   = 1'b1;
				o_alu_op      = alu_op_e'({2'b00, i_opcode[1:0]});
				// Logic immediates are zero extended.
				o_imm_sel     = i_opcode[1] ? imm_imm5_zext : imm_imm5_sext;
			end

			op_roli, op_slli, op_rori, op_srli: begin
				o_dst_sel     = dst_rd_i;
				o_imm_sel     = imm_imm5_zext;
				o_alu_src_imm = 1'b1;
				o_reg_write   = 1'b1;
				o_alu_op      = alu_op_e'({2'b01, i_opcode[1:0]});
			end

			op_beqz, op_bnez, op_bltz, op_bgez: begin
				o_imm_sel = imm_imm8_sext;
				case (i_opcode[1:0])
					2'b00:   o_br_cond = br_eqz;
					2'b01:   o_br_cond = br_nez;
					2'b10:   o_br_cond = br_ltz;
					default: o_br_cond = br_gez;
				endcase
			end

			op_st, op_ld, op_stu: begin
				o_alu_src_imm = 1'b1;
				o_alu_op      = alu_add;
				o_mem_read    = (i_opcode == op_ld);
				o_mem_write   = (i_opcode != op_ld);
				o_reg_write   = (i_opcode != op_st);
				o_dst_sel     = (i_opcode == op_stu) ? dst_rs : dst_rd_i;
				o_wb_sel      = (i_opcode == op_ld) ? wb_mem : wb_alu;
			end

			op_slbi: begin
				o_dst_sel     = dst_rs;
				o_imm_sel     = imm_imm8_zext;
				o_alu_src_imm = 1'b1;
				o_alu_op      = alu_slbi;
				o_reg_write   = 1'b1;
			end

			op_lbi: begin
				o_dst_sel   = dst_rs;
				o_imm_sel   = imm_imm8_sext;
				o_wb_sel    = wb_imm;
				o_reg_write = 1'b1;
			end

			op_btr: begin
				o_alu_op    = alu_btr;
				o_reg_write = 1'b1;
			end

			op_alu_add_sub, op_alu_logic_shift: begin
				o_alu_op    = alu_op_e'({1'b0, i_opcode[0], i_funct});
				o_reg_write = 1'b1;
			end

			op_seq, op_slt, op_sle, op_sco: begin
				o_alu_op    = alu_op_e'({2'b10, i_opcode[1:0]});
				o_reg_write = 1'b1;
			end

			default: o_err = 1'b1;
		endcase
	end

endmodule

// ==== hw/alu.sv ====
`timescale 1ns/1ps

module alu import wisc_pkg::*; (
	input  logic [DATA_W-1:0] i_a,
	input  logic [DATA_W-1:0] i_b,
	input  alu_op_e           i_op,
	output logic [DATA_W-1:0] o_result
);

	logic [DATA_W:0]     sum;
	logic [3:0]          sh;
	logic [2*DATA_W-1:0] rot_l;
	logic [2*DATA_W-1:0] rot_r;
	logic [DATA_W-1:0]   rev;

	assign sum   = {1'b0, i_a} + {1'b0, i_b};
	assign sh    = i_b[3:0];
	assign rot_l = {i_a, i_a} << sh;
	assign rot_r = {i_a, i_a} >> sh;

	always_comb begin
		for (int i = 0; i < DATA_W; i++) begin
			rev[i] = i_a[DATA_W-1-i];
		end
	end

	always_comb begin
		case (i_op)
			alu_add:    o_result = sum[DATA_W-1:0];
			// Subtract is reversed, second operand minus first.
			alu_sub:    o_result = i_b - i_a;
			alu_xor:    o_result = i_a ^ i_b;
			alu_andn:   o_result = i_a & ~i_b;
			alu_rol:    o_result = rot_l[2*DATA_W-1:DATA_W];
			alu_sll:    o_result = i_a << sh;
			alu_ror:    o_result = rot_r[DATA_W-1:0];
			alu_srl:    o_result = i_a >> sh;
			alu_seq:    o_result = {{(DATA_W-1){1'b0}}, i_a == i_b};
			alu_slt:    o_result = {{(DATA_W-1){1'b0}}, $signed(i_a) < $signed(i_b)};
			alu_sle:    o_result = {{(DATA_W-1){1'b0}}, $signed(i_a) <= $signed(i_b)};
			alu_sco:    o_result = {{(DATA_W-1){1'b0}}, sum[DATA_W]};
			alu_btr:    o_result = rev;
			alu_slbi:   o_result = {i_a[7:0], 8'h00} | i_b;
			alu_pass_b: o_result = i_b;
			default:    o_result = '0;
		endcase
	end

endmodule

// ==== hw/reg_file.sv ====
`timescale 1ns/1ps

module reg_file import wisc_pkg::*; (
	input  logic              i_clk,
	input  logic              i_rst_n,
	input  logic [REG_AW-1:0] i_rs_addr,
	input  logic [REG_AW-1:0] i_rt_addr,
	input  logic [REG_AW-1:0] i_wr_addr,
	input  logic              i_wr_en,
	input  logic [DATA_W-1:0] i_wr_data,
	output logic [DATA_W-1:0] o_rs_data,
	output logic [DATA_W-1:0] o_rt_data
);

	logic [DATA_W-1:0] regs [NREG];

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			for (int i = 0; i < NREG; i++) begin
				regs[i] <= '0;
			end
		end else if (i_wr_en) begin
			regs[i_wr_addr] <= i_wr_data;
		end
	end

	assign o_rs_data = regs[i_rs_addr];
	assign o_rt_data = regs[i_rt_addr];

endmodule

// ==== hw/pc_unit.sv ====
`timescale 1ns/1ps

module pc_unit import wisc_pkg::*; #(
	parameter logic [DATA_W-1:0] RESET_PC = '0
) (
	input  logic              i_clk,
	input  logic              i_rst_n,
	input  logic              i_advance,
	input  br_cond_e          i_br_cond,
	input  jump_e             i_jump,
	input  logic [DATA_W-1:0] i_rs_data,
	input  logic [DATA_W-1:0] i_imm,
	output logic [DATA_W-1:0] o_pc,
	output logic [DATA_W-1:0] o_pc_plus2
);

	logic [DATA_W-1:0] pc_next;
	logic              taken;

	assign o_pc_plus2 = o_pc + DATA_W'(2);

	always_comb begin
		case (i_br_cond)
			br_eqz:  taken = (i_rs_data == '0);
			br_nez:  taken = (i_rs_data != '0);
			br_ltz:  taken = i_rs_data[DATA_W-1];
			br_gez:  taken = !i_rs_data[DATA_W-1];
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		case (i_jump)
			jmp_rel: pc_next = o_pc_plus2 + i_imm;
			jmp_reg: pc_next = i_rs_data + i_imm;
			default: pc_next = taken ? o_pc_plus2 + i_imm : o_pc_plus2;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_pc <= RESET_PC;
		end else if (i_advance) begin
			o_pc <= pc_next;
		end
	end

endmodule

// ==== hw/exec_datapath.sv ====
`timescale 1ns/1ps

module exec_datapath import wisc_pkg::*; (
	input  logic              i_clk,
	input  logic              i_rst_n,
	input  logic              i_ir_load,
	input  logic              i_mdr_load,
	input  logic              i_reg_we_en,
	input  logic              i_fetch_phase,
	input  logic [DATA_W-1:0] i_mem_rdata,
	input  dst_sel_e          i_dst_sel,
	input  wb_sel_e           i_wb_sel,
	input  imm_sel_e          i_imm_sel,
	input  logic              i_alu_src_imm,
	input  alu_op_e           i_alu_op,
	input  logic [DATA_W-1:0] i_pc,
	input  logic [DATA_W-1:0] i_pc_plus2,
	output opcode_e           o_opcode,
	output logic [1:0]        o_funct,
	output logic [DATA_W-1:0] o_rs_data,
	output logic [DATA_W-1:0] o_imm,
	output logic [DATA_W-1:0] o_mem_addr,
	output logic [DATA_W-1:0] o_mem_wdata
);

	logic [DATA_W-1:0] ir;
	logic [DATA_W-1:0] mdr;
	logic [DATA_W-1:0] rt_data;
	logic [DATA_W-1:0] alu_b;
	logic [DATA_W-1:0] alu_result;
	logic [DATA_W-1:0] wr_data;
	logic [REG_AW-1:0] wr_addr;

	always_ff @(posedge i_clk) begin
		if (i_ir_load) begin
			ir <= i_mem_rdata;
		end
		if (i_mdr_load) begin
			mdr <= i_mem_rdata;
		end
	end

	assign o_opcode = opcode_e'(ir[15:11]);
	assign o_funct  = ir[1:0];

	always_comb begin
		case (i_imm_sel)
			imm_imm5_sext:   o_imm = {{(DATA_W-5){ir[4]}}, ir[4:0]};
			imm_imm5_zext:   o_imm = {{(DATA_W-5){1'b0}}, ir[4:0]};
			imm_imm8_sext:   o_imm = {{(DATA_W-8){ir[7]}}, ir[7:0]};
			imm_imm8_zext:   o_imm = {{(DATA_W-8){1'b0}}, ir[7:0]};
			imm_disp11_sext: o_imm = {{(DATA_W-11){ir[10]}}, ir[10:0]};
			default:         o_imm = '0;
		endcase
	end

	always_comb begin
		case (i_dst_sel)
			dst_rd_r: wr_addr = ir[4:2];
			dst_rd_i: wr_addr = ir[7:5];
			dst_rs:   wr_addr = ir[10:8];
			default:  wr_addr = REG_AW'(NREG - 1);
		endcase
	end

	// For stu the ALU result is the effective address written back to rs.
	always_comb begin
		case (i_wb_sel)
			wb_mem:  wr_data = mdr;
			wb_link: wr_data = i_pc_plus2;
			wb_imm:  wr_data = o_imm;
			default: wr_data = alu_result;
		endcase
	end

	assign alu_b       = i_alu_src_imm ? o_imm : rt_data;
	assign o_mem_addr  = i_fetch_phase ? i_pc : alu_result;
	assign o_mem_wdata = rt_data;

	reg_file u_reg_file (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_rs_addr (ir[10:8]),
		.i_rt_addr (ir[7:5]),
		.i_wr_addr (wr_addr),
		.i_wr_en   (i_reg_we_en),
		.i_wr_data (wr_data),
		.o_rs_data (o_rs_data),
		.o_rt_data (rt_data)
	);

	alu u_alu (
		.i_a      (o_rs_data),
		.i_b      (alu_b),
		.i_op     (i_alu_op),
		.o_result (alu_result)
	);

endmodule

// ==== hw/core_fsm.sv ====
`timescale 1ns/1ps

module core_fsm import wisc_pkg::*; (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_mem_ack,
	input  logic i_mem_read,
	input  logic i_mem_write,
	input  logic i_halt,
	input  logic i_err,
	input  logic i_reg_write,
	output logic o_mem_req,
	output logic o_mem_we,
	output logic o_fetch_phase,
	output logic o_ir_load,
	output logic o_mdr_load,
	output logic o_pc_advance,
	output logic o_reg_we_en,
	output logic o_halt,
	output logic o_err
);

	state_e state;
	state_e state_nxt;
	logic   req_q;

	always_comb begin
		state_nxt = state;
		case (state)
			s_fetch_req: begin
				if (i_mem_ack) state_nxt = s_fetch_rel;
			end
			s_fetch_rel: begin
				if (!i_mem_ack) state_nxt = s_execute;
			end
			s_execute: begin
				if (i_err) begin
					state_nxt = s_errored;
				end else if (i_halt) begin
					state_nxt = s_halted;
				end else if (i_mem_read || i_mem_write) begin
					state_nxt = s_mem_req;
				end else begin
					state_nxt = s_writeback;
				end
			end
			s_mem_req: begin
				if (i_mem_ack) state_nxt = s_mem_rel;
			end
			s_mem_rel: begin
				if (!i_mem_ack) state_nxt = s_writeback;
			end
			s_writeback: state_nxt = s_fetch_req;
			default:     state_nxt = state;
		endcase
	end

	// Request is a flop, so it stays low while reset is held.
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			state <= s_fetch_req;
			req_q <= 1'b0;
		end else begin
			state <= state_nxt;
			req_q <= (state_nxt == s_fetch_req) || (state_nxt == s_mem_req);
		end
	end

	assign o_mem_req     = req_q;
	assign o_mem_we      = (state == s_mem_req) && i_mem_write;
	assign o_fetch_phase = (state == s_fetch_req);
	assign o_ir_load     = (state == s_fetch_req) && i_mem_ack;
	assign o_mdr_load    = (state == s_mem_req) && i_mem_ack;
	assign o_pc_advance  = (state == s_writeback);
	assign o_reg_we_en   = (state == s_writeback) && i_reg_write;
	assign o_halt        = (state == s_halted);
	assign o_err         = (state == s_errored);

endmodule

// ==== hw/cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core import wisc_pkg::*; #(
	parameter logic [DATA_W-1:0] RESET_PC = '0
) (
	input  logic              i_clk,
	input  logic              i_rst_n,
	output logic              o_mem_req,
	output logic              o_mem_we,
	output logic [DATA_W-1:0] o_mem_addr,
	output logic [DATA_W-1:0] o_mem_wdata,
	input  logic              i_mem_ack,
	input  logic [DATA_W-1:0] i_mem_rdata,
	output logic              o_halt,
	output logic              o_err
);

	opcode_e           opcode;
	logic [1:0]        funct;
	dst_sel_e          dst_sel;
	wb_sel_e           wb_sel;
	imm_sel_e          imm_sel;
	alu_op_e           alu_op;
	br_cond_e          br_cond;
	jump_e             jump;
	logic              alu_src_imm;
	logic              reg_write;
	logic              mem_read;
	logic              mem_write;
	logic              dec_halt;
	logic              dec_err;
	logic              fetch_phase;
	logic              ir_load;
	logic              mdr_load;
	logic              pc_advance;
	logic              reg_we_en;
	logic [DATA_W-1:0] pc;
	logic [DATA_W-1:0] pc_plus2;
	logic [DATA_W-1:0] rs_data;
	logic [DATA_W-1:0] imm;

	control u_control (
		.i_opcode (opcode), .i_funct (funct),
		.o_dst_sel (dst_sel), .o_wb_sel (wb_sel), .o_imm_sel (imm_sel),
		.o_alu_src_imm (alu_src_imm), .o_alu_op (alu_op), .o_reg_write (reg_write),
		.o_mem_read (mem_read), .o_mem_write (mem_write),
		.o_br_cond (br_cond), .o_jump (jump), .o_halt (dec_halt), .o_err (dec_err)
	);

	core_fsm u_core_fsm (
		.i_clk (i_clk), .i_rst_n (i_rst_n), .i_mem_ack (i_mem_ack),
		.i_mem_read (mem_read), .i_mem_write (mem_write),
		.i_halt (dec_halt), .i_err (dec_err), .i_reg_write (reg_write),
		.o_mem_req (o_mem_req), .o_mem_we (o_mem_we), .o_fetch_phase (fetch_phase),
		.o_ir_load (ir_load), .o_mdr_load (mdr_load), .o_pc_advance (pc_advance),
		.o_reg_we_en (reg_we_en), .o_halt (o_halt), .o_err (o_err)
	);

	pc_unit #(.RESET_PC(RESET_PC)) u_pc_unit (
		.i_clk (i_clk), .i_rst_n (i_rst_n), .i_advance (pc_advance),
		.i_br_cond (br_cond), .i_jump (jump), .i_rs_data (rs_data), .i_imm (imm),
		.o_pc (pc), .o_pc_plus2 (pc_plus2)
	);

	exec_datapath u_exec_datapath (
		.i_clk (i_clk), .i_rst_n (i_rst_n), .i_ir_load (ir_load), .i_mdr_load (mdr_load),
		.i_reg_we_en (reg_we_en), .i_fetch_phase (fetch_phase), .i_mem_rdata (i_mem_rdata),
		.i_dst_sel (dst_sel), .i_wb_sel (wb_sel), .i_imm_sel (imm_sel),
		.i_alu_src_imm (alu_src_imm), .i_alu_op (alu_op),
		.i_pc (pc), .i_pc_plus2 (pc_plus2),
		.o_opcode (opcode), .o_funct (funct), .o_rs_data (rs_data), .o_imm (imm),
		.o_mem_addr (o_mem_addr), .o_mem_wdata (o_mem_wdata)
	);

endmodule

// ==== test/cpu_asserts.sv ====
`timescale 1ns/1ps

module cpu_asserts import wisc_pkg::*; (
	input logic              i_clk,
	input logic              i_rst_n,
	input logic              o_mem_req,
	input logic              o_mem_we,
	input logic [DATA_W-1:0] o_mem_addr,
	input logic [DATA_W-1:0] o_mem_wdata,
	input logic              i_mem_ack,
	input logic              o_halt,
	input logic              o_err
);

	// New request only after the previous ack has dropped.
	req_after_ack_low: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$rose(o_mem_req) |-> !$past(i_mem_ack))
		else $error("memory request raised while ack still high");

	req_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(o_mem_req && !i_mem_ack) |=>
		($stable(o_mem_addr) && $stable(o_mem_we) && $stable(o_mem_wdata)))
		else $error("request fields changed before ack");

	stop_exclusive: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(o_halt && o_err))
		else $error("halt and error both high");

	quiet_after_stop: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(o_halt || o_err) |-> !o_mem_req)
		else $error("memory request after stop");

endmodule

bind cpu_core cpu_asserts u_cpu_asserts (
	.i_clk       (i_clk),
	.i_rst_n     (i_rst_n),
	.o_mem_req   (o_mem_req),
	.o_mem_we    (o_mem_we),
	.o_mem_addr  (o_mem_addr),
	.o_mem_wdata (o_mem_wdata),
	.i_mem_ack   (i_mem_ack),
	.o_halt      (o_halt),
	.o_err       (o_err)
);

// ==== test/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb;

	localparam logic [15:0] RESET_PC = 16'h0000;
	localparam logic [4:0] OP_HALT = 5'd0;
	localparam logic [4:0] OP_NOP = 5'd1;
	localparam logic [4:0] OP_SIIC = 5'd2;
	localparam logic [4:0] OP_J = 5'd4;
	localparam logic [4:0] OP_JR = 5'd5;
	localparam logic [4:0] OP_JAL = 5'd6;
	localparam logic [4:0] OP_JALR = 5'd7;
	localparam logic [4:0] OP_ST = 5'd16;
	localparam logic [4:0] OP_LD = 5'd17;
	localparam logic [4:0] OP_SLBI = 5'd18;
	localparam logic [4:0] OP_STU = 5'd19;
	localparam logic [4:0] OP_LBI = 5'd24;

	logic        clk;
	logic        rst_n;
	logic        mem_req;
	logic        mem_we;
	logic [15:0] mem_addr;
	logic [15:0] mem_wdata;
	logic        mem_ack;
	logic [15:0] mem_rdata;
	logic        halt;
	logic        err;

	logic [15:0] mem [256];
	logic [15:0] prog [$];
	logic [31:0] exp_q [$];
	logic [31:0] act_q [$];
	integer      seed = 32'h5860;
	int          wait_cnt;
	bit          force_max;
	bit          pre_en;
	logic [15:0] pre_addr;
	logic [15:0] pre_data;
	int          passed;
	int          failed;
	int          cycles;
	int          limit;
	string       cur_name;
	logic [15:0] a;
	logic [15:0] b;
	logic [15:0] w;

	cpu_core #(.RESET_PC(RESET_PC)) uut (
		.i_clk (clk), .i_rst_n (rst_n),
		.o_mem_req (mem_req), .o_mem_we (mem_we), .o_mem_addr (mem_addr),
		.o_mem_wdata (mem_wdata), .i_mem_ack (mem_ack), .i_mem_rdata (mem_rdata),
		.o_halt (halt), .o_err (err)
	);

	always #5 clk = ~clk;

	function automatic int next_delay();
		int d;
		d = $unsigned($random(seed)) % 4;
		return force_max ? 3 : d;
	endfunction

	// Four-phase memory, driven on the falling edge.
	always @(negedge clk) begin
		if (!rst_n) begin
			mem_ack = 1'b0;
			wait_cnt = next_delay();
		end else if (mem_req && !mem_ack) begin
			if (wait_cnt == 0) begin
				mem_ack = 1'b1;
				mem_rdata = mem[mem_addr[8:1]];
				if (mem_we) begin
					mem[mem_addr[8:1]] = mem_wdata;
					act_q.push_back({mem_addr, mem_wdata});
				end
				wait_cnt = next_delay();
			end else begin
				wait_cnt--;
			end
		end else if (!mem_req && mem_ack) begin
			mem_ack = 1'b0;
		end
	end

	// Stops the run when a test does not reach halt or error in time.
	initial begin
		wait (cycles > limit);
		$display("%s: no stop within %0d cycles", cur_name, limit);
		$display("sim failed");
		$finish;
	end

	function automatic logic [15:0] ref_alu(input int op, input logic [15:0] x,
		input logic [15:0] y);
		logic [16:0] s;
		logic [3:0]  n;
		logic [15:0] r;
		s = {1'b0, x} + {1'b0, y};
		n = y[3:0];
		case (op)
			0: r = s[15:0];
			1: r = y - x;
			2: r = x ^ y;
			3: r = x & ~y;
			4: r = (x << n) | (x >> (16 - n));
			5: r = x << n;
			6: r = (x >> n) | (x << (16 - n));
			7: r = x >> n;
			8: r = {15'd0, x == y};
			9: r = {15'd0, $signed(x) < $signed(y)};
			10: r = {15'd0, $signed(x) <= $signed(y)};
			11: r = {15'd0, s[16]};
			default: begin
				for (int i = 0; i < 16; i++) begin
					r[i] = x[15-i];
				end
			end
		endcase
		return r;
	endfunction

	function automatic logic [15:0] enc_i5(input logic [4:0] op, input logic [2:0] rs,
		input logic [2:0] rd, input logic [4:0] imm);
		return {op, rs, rd, imm};
	endfunction

	function automatic logic [15:0] enc_i8(input logic [4:0] op, input logic [2:0] rs,
		input logic [7:0] imm);
		return {op, rs, imm};
	endfunction

	task automatic load_word(input logic [2:0] r, input logic [15:0] v);
		prog.push_back(enc_i8(OP_LBI, r, v[15:8]));
		prog.push_back(enc_i8(OP_SLBI, r, v[7:0]));
	endtask

	task automatic build_alu(input logic [15:0] x, input logic [15:0] y);
		logic [4:0]  imm;
		logic [15:0] bi;
		prog.delete();
		exp_q.delete();
		load_word(1, x);
		load_word(2, y);
		load_word(4, 16'h0100);
		for (int k = 0; k < 13; k++) begin
			if (k < 8) begin
				prog.push_back({(k < 4) ? 5'd26 : 5'd27, 3'd1, 3'd2, 3'd3, 2'(k)});
			end else if (k < 12) begin
				prog.push_back({5'(28 + k - 8), 3'd1, 3'd2, 3'd3, 2'd0});
			end else begin
				prog.push_back({5'd25, 3'd1, 3'd2, 3'd3, 2'd0});
			end
			prog.push_back(enc_i5(OP_ST, 4, 3, 0));
			exp_q.push_back({16'h0100, ref_alu(k, x, y)});
		end
		// Immediate forms: addi, subi, xori, andni, roli, slli, rori, srli.
		for (int k = 0; k < 8; k++) begin
			imm = 5'h13 + 5'(k * 3);
			bi = (k < 2) ? {{11{imm[4]}}, imm} : {11'd0, imm};
			prog.push_back(enc_i5((k < 4) ? 5'(8 + k) : 5'(20 + k - 4), 1, 3, imm));
			prog.push_back(enc_i5(OP_ST, 4, 3, 0));
			exp_q.push_back({16'h0100, ref_alu(k, x, bi)});
		end
		prog.push_back({OP_HALT, 11'd0});
	endtask

	task automatic run_test(input string name, input bit want_halt);
		int errs;
		errs = 0;
		for (int i = 0; i < 256; i++) begin
			mem[i] = 16'(i * 16'h0101) ^ 16'h5A3C;
		end
		foreach (prog[i]) mem[RESET_PC[8:1] + i] = prog[i];
		if (pre_en) mem[pre_addr[8:1]] = pre_data;
		act_q.delete();
		cur_name = name;
		cycles = 0;
		// Each instruction takes at most two slow handshakes plus two cycles.
		limit = prog.size() * 24;
		rst_n = 1'b0;
		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		while (!halt && !err) begin
			@(negedge clk);
			cycles++;
		end
		repeat (5) begin
			@(negedge clk);
			if (mem_req) begin
				$display("%s: memory request seen after stop", name);
				errs++;
			end
		end
		if (want_halt && !(halt && !err)) begin
			$display("%s: core did not end with halt alone", name);
			errs++;
		end
		if (!want_halt && !(err && !halt)) begin
			$display("%s: core did not end with error alone", name);
			errs++;
		end
		if (act_q.size() != exp_q.size()) begin
			$display("FAIL %s write count expected %0d actual %0d", name, exp_q.size(),
				act_q.size());
			errs++;
		end else begin
			foreach (exp_q[i]) begin
				if (act_q[i] !== exp_q[i]) begin
					$display("FAIL %s write %0d expected %h actual %h", name, i, exp_q[i],
						act_q[i]);
					errs++;
				end
			end
		end
		if (errs == 0) begin
			$display("PASS %s", name);
			passed++;
		end else begin
			$display("FAIL %s with %0d errors", name, errs);
			failed++;
		end
	endtask

	initial begin
		logic [7:0]  vals [3];
		logic [15:0] v;
		bit          taken;
		clk = 1'b0;
		rst_n = 1'b0;
		mem_ack = 1'b0;
		mem_rdata = '0;
		force_max = 1'b0;
		pre_en = 1'b0;
		passed = 0;
		failed = 0;
		cycles = 0;
		limit = 0;
		a = $random(seed);
		b = $random(seed);
		w = $random(seed);

		build_alu(a, b);
		run_test("alu_ops", 1'b1);

		prog.delete();
		exp_q.delete();
		pre_en = 1'b1;
		pre_addr = 16'h0120;
		pre_data = w;
		load_word(4, 16'h0100);
		load_word(6, 16'h0120);
		prog.push_back(enc_i5(OP_LD, 6, 5, 0));
		prog.push_back(enc_i5(OP_ST, 4, 5, 6));
		prog.push_back(enc_i5(OP_STU, 4, 5, 5'h1c));
		prog.push_back(enc_i5(OP_ST, 6, 4, 2));
		prog.push_back({OP_HALT, 11'd0});
		exp_q.push_back({16'h0106, w});
		exp_q.push_back({16'h00fc, w});
		exp_q.push_back({16'h0122, 16'h00fc});
		run_test("load_store", 1'b1);
		pre_en = 1'b0;

		prog.delete();
		exp_q.delete();
		vals[0] = 8'h00;
		vals[1] = 8'h25;
		vals[2] = 8'ha3;
		load_word(4, 16'h0100);
		for (int op = 12; op < 16; op++) begin
			for (int k = 0; k < 3; k++) begin
				v = {{8{vals[k][7]}}, vals[k]};
				case (op)
					12: taken = (v == 0);
					13: taken = (v != 0);
					14: taken = v[15];
					default: taken = !v[15];
				endcase
				prog.push_back(enc_i8(OP_LBI, 1, vals[k]));
				prog.push_back(enc_i8(5'(op), 1, 8'h02));
				prog.push_back(enc_i5(OP_ST, 4, 1, 0));
				if (!taken) exp_q.push_back({16'h0100, v});
			end
		end
		prog.push_back({OP_HALT, 11'd0});
		run_test("branches", 1'b1);

		prog.delete();
		exp_q.delete();
		load_word(4, 16'h0100);
		prog.push_back({OP_J, 11'd2});
		prog.push_back(enc_i5(OP_ST, 4, 4, 0));
		prog.push_back({OP_JAL, 11'd2});
		prog.push_back(enc_i5(OP_ST, 4, 4, 0));
		prog.push_back(enc_i5(OP_ST, 4, 7, 0));
		prog.push_back(enc_i8(OP_LBI, 2, 8'd22));
		prog.push_back(enc_i8(OP_JR, 2, 8'd0));
		prog.push_back(enc_i5(OP_ST, 4, 4, 0));
		prog.push_back(enc_i5(OP_ST, 4, 4, 0));
		prog.push_back(enc_i8(OP_LBI, 2, 8'd30));
		prog.push_back(enc_i8(OP_JALR, 2, 8'd0));
		prog.push_back(enc_i5(OP_ST, 4, 4, 0));
		prog.push_back(enc_i5(OP_ST, 4, 4, 0));
		prog.push_back(enc_i5(OP_ST, 4, 7, 0));
		prog.push_back({OP_HALT, 11'd0});
		exp_q.push_back({16'h0100, 16'd10});
		exp_q.push_back({16'h0100, 16'd26});
		run_test("jumps", 1'b1);

		prog.delete();
		exp_q.delete();
		prog.push_back({OP_NOP, 11'd0});
		prog.push_back({OP_HALT, 11'd0});
		run_test("halt", 1'b1);

		prog.delete();
		prog.push_back({OP_NOP, 11'd0});
		prog.push_back({OP_SIIC, 11'd0});
		prog.push_back({OP_HALT, 11'd0});
		run_test("illegal_siic", 1'b0);

		force_max = 1'b1;
		build_alu(a, b);
		run_test("alu_backpressure", 1'b1);

		$display("tests passed %0d failed %0d", passed, failed);
		if (failed == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// ==== build.f ====
hw/wisc_pkg.sv
hw/control.sv
hw/alu.sv
hw/reg_file.sv
hw/pc_unit.sv
hw/exec_datapath.sv
hw/core_fsm.sv
hw/cpu_core.sv
test/cpu_asserts.sv
test/cpu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then check the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb \
	-f build.f -o cpu_sim > build.log 2>&1 \
	|| { echo "build error, see build.log"; exit 1; }

./obj_dir/cpu_sim > sim.log 2>&1 || true

grep -qx "sim passed" sim.log && echo "run ok" \
	|| { echo "run failed, see sim.log"; exit 1; }
